//--- Bender.yml
package:
  name: decoder_mips

sources:
  - include_dirs:
      - source
    files:
      - source/decoder_pkg.sv
      - source/instr_decoder.sv
      - source/cond_evaluator.sv
      - source/id_ex_control.sv
      - source/decoder_mips.sv
  - target: test
    include_dirs:
      - source
    files:
      - tests/decoder_mips_sva.sv
      - tests/tb_decoder_mips.sv

//--- all.f
+incdir+source
source/decoder_pkg.sv
source/instr_decoder.sv
source/cond_evaluator.sv
source/id_ex_control.sv
source/decoder_mips.sv
tests/decoder_mips_sva.sv
tests/tb_decoder_mips.sv

//--- source/cond_evaluator.sv
// ----------------------------------------------------------------------
// Evaluates all branch conditions and both set-less-than results
// from the datapath flags, independent of the current instruction
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module cond_evaluator (
	input  logic equalrsrt,
	input  logic rsneg,
	input  logic rsmaior,
	input  logic rsmrt,
	// One bit per branch_cond_e value
	output logic [2**$bits(decoder_pkg::branch_cond_e)-1:0] cond_met,
	output logic set_imm,
	output logic set_reg
);
	import decoder_pkg::*;

	always_comb
	begin
		// Not a branch
		cond_met[COND_NONE]   = 1'b0;
		// Jumps always taken
		cond_met[COND_ALWAYS] = 1'b1;
		// rs == rt
		cond_met[COND_EQ]     = equalrsrt;
		cond_met[COND_NE]     = ~equalrsrt;
		// rs <= 0, zero shows up as equal
		cond_met[COND_LEZ]    = equalrsrt | rsneg;
		cond_met[COND_GTZ]    = ~(equalrsrt | rsneg);
		// Sign of rs only
		cond_met[COND_LTZ]    = rsneg;
		cond_met[COND_GEZ]    = ~rsneg;
	end

	// SLTI/SLTIU, rs is less when not greater
	assign set_imm = ~rsmaior;
	// SLT/SLTU, flag already means rs < rt
	assign set_reg = rsmrt;

endmodule

//--- source/decoder_defs.svh
// ----------------------------------------------------------------------
// Field and bus widths for the MIPS instruction decoder
// Include wherever a port or register width depends on them
// ----------------------------------------------------------------------
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// Instruction fields
`define DEC_OPCODE_W 6
`define DEC_FUNCT_W 6
`define DEC_RT_W 5

// ALU operation code, matches the ALU
`define DEC_ALU_OP_W 4

// Datapath word and control word
`define DEC_DATA_W 32
`define DEC_CTRL_W 8

`endif

//--- source/decoder_mips.sv
// ----------------------------------------------------------------------
// MIPS instruction decoder, top level
// Field decode and flag evaluation run side by side, results are
// registered together, outputs valid one cycle after the inputs
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "decoder_defs.svh"

module decoder_mips (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic [`DEC_OPCODE_W-1:0] opcode,
	input  logic [`DEC_FUNCT_W-1:0]  funct,
	input  logic [`DEC_RT_W-1:0]     rt_code,
	input  logic                     equalrsrt,
	input  logic                     rsmaior,
	input  logic                     rsmrt,
	input  logic                     rsneg,
	output logic [`DEC_CTRL_W-1:0]   ctrol,
	output logic [`DEC_ALU_OP_W-1:0] outsaida,
	output logic [`DEC_DATA_W-1:0]   rt,
	output logic                     slt_mux,
	output logic                     zero_ext,
	output logic                     jr_ctrl
);
	import decoder_pkg::*;

	// Decode to register stage
	logic [`DEC_CTRL_W-1:0]       static_ctrl;
	alu_op_e                      alu_op;
	branch_cond_e                 cond_sel;
	set_src_e                     set_src;
	logic                         zero_ext_d;
	logic                         jr_d;
	// Flag evaluation to register stage
	logic [2**$bits(branch_cond_e)-1:0] cond_met;
	logic                         set_imm;
	logic                         set_reg;

	// Raw opcode bits, unlisted values fall to the no-op
	instr_decoder u_instr_decoder (
		.opcode      (opcode_e'(opcode)),
		.funct       (funct),
		.rt_code     (rt_code),
		.static_ctrl (static_ctrl),
		.alu_op      (alu_op),
		.cond_sel    (cond_sel),
		.set_src     (set_src),
		.zero_ext_d  (zero_ext_d),
		.jr_d        (jr_d)
	);

	cond_evaluator u_cond_evaluator (
		.equalrsrt (equalrsrt),
		.rsneg     (rsneg),
		.rsmaior   (rsmaior),
		.rsmrt     (rsmrt),
		.cond_met  (cond_met),
		.set_imm   (set_imm),
		.set_reg   (set_reg)
	);

	id_ex_control u_id_ex_control (
		.clk         (clk),
		.rst_n       (rst_n),
		.static_ctrl (static_ctrl),
		.alu_op      (alu_op),
		.cond_sel    (cond_sel),
		.set_src     (set_src),
		.zero_ext_d  (zero_ext_d),
		.jr_d        (jr_d),
		.cond_met    (cond_met),
		.set_imm     (set_imm),
		.set_reg     (set_reg),
		.ctrol       (ctrol),
		.outsaida    (outsaida),
		.rt          (rt),
		.slt_mux     (slt_mux),
		.zero_ext    (zero_ext),
		.jr_ctrl     (jr_ctrl)
	);

endmodule

//--- source/decoder_pkg.sv
// ----------------------------------------------------------------------
// Shared types of the MIPS instruction decoder
// Major opcodes, ALU operations, branch conditions and set sources
// ----------------------------------------------------------------------
`include "decoder_defs.svh"

package decoder_pkg;

	// Major opcodes that the decoder keeps
	typedef enum logic [`DEC_OPCODE_W-1:0] {
		OP_SPECIAL = 6'd0,
		OP_REGIMM  = 6'd1,
		OP_J       = 6'd2,
		OP_JAL     = 6'd3,
		OP_BEQ     = 6'd4,
		OP_BNE     = 6'd5,
		OP_BLEZ    = 6'd6,
		OP_BGTZ    = 6'd7,
		OP_ADDI    = 6'd8,
		OP_ADDIU   = 6'd9,
		OP_SLTI    = 6'd10,
		OP_SLTIU   = 6'd11,
		OP_ANDI    = 6'd12,
		OP_ORI     = 6'd13,
		OP_XORI    = 6'd14,
		OP_LW      = 6'd35,
		OP_SW      = 6'd43
	} opcode_e;

	// ALU operation codes, same encoding as the ALU
	typedef enum logic [`DEC_ALU_OP_W-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd8,
		ALU_COMP = 4'd11
	} alu_op_e;

	// Branch condition, also the index into cond_met
	typedef enum logic [2:0] {
		COND_NONE,
		COND_ALWAYS,
		COND_EQ,
		COND_NE,
		COND_LEZ,
		COND_GTZ,
		COND_LTZ,
		COND_GEZ
	} branch_cond_e;

	// Where the set-less-than result comes from
	typedef enum logic [1:0] {
		SET_NONE,
		// Immediate compare, rsmaior flag
		SET_IMM,
		// Register compare, rsmrt flag
		SET_REG
	} set_src_e;

endpackage

//--- source/id_ex_control.sv
// ----------------------------------------------------------------------
// Decode/execute boundary register
// Merges the static decode with the evaluated flags, then registers
// every output, one cycle latency, synchronous active-low reset
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "decoder_defs.svh"

module id_ex_control (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  logic [`DEC_CTRL_W-1:0]                       static_ctrl,
	input  decoder_pkg::alu_op_e                         alu_op,
	input  decoder_pkg::branch_cond_e                    cond_sel,
	input  decoder_pkg::set_src_e                        set_src,
	input  logic                                         zero_ext_d,
	input  logic                                         jr_d,
	input  logic [2**$bits(decoder_pkg::branch_cond_e)-1:0] cond_met,
	input  logic                                         set_imm,
	input  logic                                         set_reg,
	output logic [`DEC_CTRL_W-1:0]                       ctrol,
	output decoder_pkg::alu_op_e                         outsaida,
	output logic [`DEC_DATA_W-1:0]                       rt,
	output logic                                         slt_mux,
	output logic                                         zero_ext,
	output logic                                         jr_ctrl
);
	import decoder_pkg::*;

	// ------------------------------------------------------------------
	// Next-state values
	// ------------------------------------------------------------------
	logic                   jorf_d;
	logic [`DEC_CTRL_W-1:0] ctrol_d;
	logic                   set_bit_d;
	logic                   slt_mux_d;

	// Condition picked by the decoded branch type
	assign jorf_d  = cond_met[cond_sel];
	// Insert jorf into bit 7
	assign ctrol_d = {jorf_d, static_ctrl[`DEC_CTRL_W-2:0]};

	always_comb
	begin
		case (set_src)
			SET_IMM:  set_bit_d = set_imm;
			SET_REG:  set_bit_d = set_reg;
			default:  set_bit_d = 1'b0;
		endcase
	end

	// Decoder drives rt on every set-less-than
	assign slt_mux_d = (set_src != SET_NONE);

	// ------------------------------------------------------------------
	// Pipeline register
	// ------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			// Write enables and jorf inactive out of reset
			ctrol    <= '0;
			outsaida <= ALU_ADD;
			rt       <= '0;
			slt_mux  <= 1'b0;
			zero_ext <= 1'b0;
			jr_ctrl  <= 1'b0;
		end
		else
		begin
			ctrol    <= ctrol_d;
			outsaida <= alu_op;
			rt       <= {{(`DEC_DATA_W-1){1'b0}}, set_bit_d};
			slt_mux  <= slt_mux_d;
			zero_ext <= zero_ext_d;
			jr_ctrl  <= jr_d;
		end
	end

endmodule

//--- source/instr_decoder.sv
// ----------------------------------------------------------------------
// Static field decode of opcode, funct and rt
// Gives control bits, ALU operation, branch condition and set source
// Purely combinational, jorf is resolved later from the flags
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "decoder_defs.svh"

module instr_decoder (
	input  decoder_pkg::opcode_e       opcode,
	input  logic [`DEC_FUNCT_W-1:0]    funct,
	input  logic [`DEC_RT_W-1:0]       rt_code,
	output logic [`DEC_CTRL_W-1:0]     static_ctrl,
	output decoder_pkg::alu_op_e       alu_op,
	output decoder_pkg::branch_cond_e  cond_sel,
	output decoder_pkg::set_src_e      set_src,
	output logic                       zero_ext_d,
	output logic                       jr_d
);
	import decoder_pkg::*;

	// SPECIAL funct values that are kept
	localparam logic [`DEC_FUNCT_W-1:0] FN_JR   = 6'd8;
	localparam logic [`DEC_FUNCT_W-1:0] FN_JALR = 6'd9;
	localparam logic [`DEC_FUNCT_W-1:0] FN_ADD  = 6'd32;
	localparam logic [`DEC_FUNCT_W-1:0] FN_ADDU = 6'd33;
	localparam logic [`DEC_FUNCT_W-1:0] FN_SUB  = 6'd34;
	localparam logic [`DEC_FUNCT_W-1:0] FN_SUBU = 6'd35;
	localparam logic [`DEC_FUNCT_W-1:0] FN_AND  = 6'd36;
	localparam logic [`DEC_FUNCT_W-1:0] FN_OR   = 6'd37;
	localparam logic [`DEC_FUNCT_W-1:0] FN_XOR  = 6'd38;
	localparam logic [`DEC_FUNCT_W-1:0] FN_NOR  = 6'd39;
	localparam logic [`DEC_FUNCT_W-1:0] FN_SLT  = 6'd42;
	localparam logic [`DEC_FUNCT_W-1:0] FN_SLTU = 6'd43;

	// Individual control bits, packed below
	logic ctrl;
	logic addorn;
	logic rori;
	logic instype;
	logic reoral;
	logic ref_w_ena;
	logic d_mem_wena;
	// Any R-type with register write-back
	logic r_alu;

	always_comb
	begin
		// No-op defaults, also for every unlisted encoding
		ctrl       = 1'b0;
		addorn     = 1'b0;
		rori       = 1'b0;
		instype    = 1'b0;
		reoral     = 1'b0;
		ref_w_ena  = 1'b0;
		d_mem_wena = 1'b0;
		r_alu      = 1'b0;
		alu_op     = ALU_ADD;
		cond_sel   = COND_NONE;
		set_src    = SET_NONE;
		zero_ext_d = 1'b0;
		jr_d       = 1'b0;

		case (opcode)
			OP_SW:
				d_mem_wena = 1'b1;
			OP_LW:
			begin
				instype   = 1'b1;
				ref_w_ena = 1'b1;
			end
			OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU:
			begin
				// Immediate group, result goes to rt
				instype   = 1'b1;
				reoral    = 1'b1;
				ref_w_ena = 1'b1;
				case (opcode)
					OP_ANDI:  alu_op = ALU_AND;
					OP_ORI:   alu_op = ALU_OR;
					OP_XORI:  alu_op = ALU_XOR;
					default:  alu_op = ALU_ADD;
				endcase
				// Logical immediates are zero extended
				zero_ext_d = (opcode == OP_ANDI) || (opcode == OP_ORI) ||
					(opcode == OP_XORI);
				if (opcode == OP_SLTI || opcode == OP_SLTIU)
					set_src = SET_IMM;
			end
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM:
			begin
				// Compare rs and rt in the ALU
				rori    = 1'b1;
				instype = 1'b1;
				reoral  = 1'b1;
				alu_op  = ALU_COMP;
				case (opcode)
					OP_BEQ:   cond_sel = COND_EQ;
					OP_BNE:   cond_sel = COND_NE;
					OP_BLEZ:  cond_sel = COND_LEZ;
					OP_BGTZ:  cond_sel = COND_GTZ;
					// REGIMM, rt 0 is BLTZ, anything else BGEZ
					default:  cond_sel = (rt_code == '0) ? COND_LTZ : COND_GEZ;
				endcase
			end
			OP_J, OP_JAL:
			begin
				ctrl     = 1'b1;
				cond_sel = COND_ALWAYS;
			end
			OP_SPECIAL:
			begin
				case (funct)
					FN_JR, FN_JALR:
					begin
						// PC from rs
						cond_sel = COND_ALWAYS;
						jr_d     = 1'b1;
					end
					FN_ADD, FN_ADDU:  r_alu = 1'b1;
					FN_SUB, FN_SUBU:
					begin
						r_alu  = 1'b1;
						alu_op = ALU_SUB;
					end
					FN_AND:
					begin
						r_alu  = 1'b1;
						alu_op = ALU_AND;
					end
					FN_OR:
					begin
						r_alu  = 1'b1;
						alu_op = ALU_OR;
					end
					FN_XOR:
					begin
						r_alu  = 1'b1;
						alu_op = ALU_XOR;
					end
					FN_NOR:
					begin
						r_alu  = 1'b1;
						alu_op = ALU_NOR;
					end
					FN_SLT, FN_SLTU:
					begin
						r_alu   = 1'b1;
						set_src = SET_REG;
					end
					// Shifts and the rest stay no-op
					default:  r_alu = 1'b0;
				endcase
				// R-type write-back to rd
				addorn    = r_alu;
				rori      = r_alu;
				reoral    = r_alu;
				ref_w_ena = r_alu;
			end
			default:
				alu_op = ALU_ADD;
		endcase
	end

	// jorf slot stays 0 here
	assign static_ctrl = {1'b0, ctrl, addorn, rori, instype, reoral, ref_w_ena, d_mem_wena};

endmodule

//--- tests/decoder_mips_sva.sv
// ----------------------------------------------------------------------
// Concurrent assertions on the decoder outputs
// Bound to every decoder_mips instance, failures also counted
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "decoder_defs.svh"

module decoder_mips_sva (
	input logic                     clk,
	input logic                     rst_n,
	input logic [`DEC_CTRL_W-1:0]   ctrol,
	input logic [`DEC_ALU_OP_W-1:0] outsaida,
	input logic [`DEC_DATA_W-1:0]   rt,
	input logic                     slt_mux,
	input logic                     zero_ext,
	input logic                     jr_ctrl
);

	// Failures seen so far
	int n_fail = 0;

	// Register file and memory never written by the same instruction
	a_wen_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrol[1] && ctrol[0]))
		else
		begin
			$error("register write and memory write enabled together");
			n_fail++;
		end

	// Jump through a register always redirects the PC
	a_jr_jorf: assert property (@(posedge clk) disable iff (!rst_n)
		jr_ctrl |-> ctrol[7])
		else
		begin
			$error("jr_ctrl set without jorf");
			n_fail++;
		end

	// Reset clears every output one edge later
	a_reset_clear: assert property (@(posedge clk)
		!rst_n |=> (ctrol == '0 && outsaida == '0 && rt == '0 &&
			!slt_mux && !zero_ext && !jr_ctrl))
		else
		begin
			$error("outputs not cleared after a reset edge");
			n_fail++;
		end

endmodule

bind decoder_mips decoder_mips_sva u_sva (
	.clk      (clk),
	.rst_n    (rst_n),
	.ctrol    (ctrol),
	.outsaida (outsaida),
	.rt       (rt),
	.slt_mux  (slt_mux),
	.zero_ext (zero_ext),
	.jr_ctrl  (jr_ctrl)
);

//--- tests/tb_decoder_mips.sv
// ----------------------------------------------------------------------
// Testbench for the registered MIPS decoder
// Drives on the falling edge, compares one cycle later against a
// reference model, random fields from a 32-bit Fibonacci LFSR
// ----------------------------------------------------------------------
`timescale 1ns/1ps
`include "decoder_defs.svh"

module tb_decoder_mips;
	import decoder_pkg::*;

	localparam int CLK_PERIOD = 4;
	// Vector counts per test group
	localparam int N_RESET    = 4;
	localparam int N_KEPT     = 28 * 4;
	localparam int N_BRANCH   = 8 * 16;
	localparam int N_SLT      = 4 * 16;
	localparam int N_NOOP     = 7 + 40;
	localparam int N_B2B      = 200;
	localparam int TOTAL_VEC  = N_RESET + N_KEPT + N_BRANCH + N_SLT + N_NOOP + N_B2B;
	localparam int TIMEOUT_NS = (TOTAL_VEC + 20) * CLK_PERIOD;

	logic clk;
	logic rst_n;
	logic [`DEC_OPCODE_W-1:0] opcode;
	logic [`DEC_FUNCT_W-1:0]  funct;
	logic [`DEC_RT_W-1:0]     rt_code;
	logic equalrsrt;
	logic rsmaior;
	logic rsmrt;
	logic rsneg;
	logic [`DEC_CTRL_W-1:0]   ctrol;
	logic [`DEC_ALU_OP_W-1:0] outsaida;
	logic [`DEC_DATA_W-1:0]   rt;
	logic slt_mux;
	logic zero_ext;
	logic jr_ctrl;

	// Test bookkeeping
	logic [31:0] lfsr;
	logic check_en;
	string cur_name;
	int n_driven;
	int n_checked;
	int n_mismatch;
	int n_other;
	logic [5:0] kept_ops [16];
	logic [5:0] kept_fns [12];
	logic [5:0] shift_fns [6];

	decoder_mips DUT (.*);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One LFSR step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	// ------------------------------------------------------------------
	// Reference model, {ctrol, outsaida, rt, slt_mux, zero_ext, jr_ctrl}
	// ------------------------------------------------------------------
	function automatic logic [46:0] expected_out(input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] rtc, input logic eq, input logic maior,
			input logic mrt, input logic neg);
		logic [7:0] c;
		logic [3:0] alu;
		logic set_b;
		logic sm;
		logic ze;
		logic jr;
		logic is_br;
		logic take;
		c = 8'h00;
		alu = ALU_ADD;
		set_b = 1'b0;
		sm = 1'b0;
		ze = 1'b0;
		jr = 1'b0;
		is_br = 1'b0;
		take = 1'b0;
		case (op)
			OP_SW:  c = 8'b0000_0001;
			OP_LW:  c = 8'b0000_1010;
			OP_ADDI, OP_ADDIU:  c = 8'b0000_1110;
			OP_ANDI, OP_ORI, OP_XORI:
			begin
				c = 8'b0000_1110;
				ze = 1'b1;
				alu = (op == OP_ANDI) ? ALU_AND : (op == OP_ORI) ? ALU_OR : ALU_XOR;
			end
			OP_SLTI, OP_SLTIU:
			begin
				c = 8'b0000_1110;
				sm = 1'b1;
				set_b = !maior;
			end
			OP_BEQ:
			begin
				is_br = 1'b1;
				take = eq;
			end
			OP_BNE:
			begin
				is_br = 1'b1;
				take = !eq;
			end
			OP_BLEZ:
			begin
				is_br = 1'b1;
				take = eq || neg;
			end
			OP_BGTZ:
			begin
				is_br = 1'b1;
				take = !eq && !neg;
			end
			// BLTZ for rt 0, BGEZ otherwise
			OP_REGIMM:
			begin
				is_br = 1'b1;
				take = (rtc == 5'd0) ? neg : !neg;
			end
			OP_J, OP_JAL:  c = 8'b1100_0000;
			OP_SPECIAL:
			begin
				if (fn == 6'd8 || fn == 6'd9)
				begin
					c = 8'b1000_0000;
					jr = 1'b1;
				end
				else if ((fn >= 6'd32 && fn <= 6'd39) || fn == 6'd42 || fn == 6'd43)
				begin
					c = 8'b0011_0110;
					case (fn)
						6'd34, 6'd35:  alu = ALU_SUB;
						6'd36:  alu = ALU_AND;
						6'd37:  alu = ALU_OR;
						6'd38:  alu = ALU_XOR;
						6'd39:  alu = ALU_NOR;
						default:  alu = ALU_ADD;
					endcase
					sm = (fn == 6'd42 || fn == 6'd43);
					set_b = sm && mrt;
				end
			end
			default:  c = 8'h00;
		endcase
		if (is_br)
		begin
			c = {take, 7'b001_1100};
			alu = ALU_COMP;
		end
		expected_out = {c, alu, 31'd0, set_b, sm, ze, jr};
	endfunction

	// Flags packed as {equalrsrt, rsmaior, rsmrt, rsneg}
	task automatic apply(input string name, input logic [5:0] op, input logic [5:0] fn,
			input logic [4:0] rtc, input logic [3:0] flags);
		@(negedge clk);
		opcode = op;
		funct = fn;
		rt_code = rtc;
		{equalrsrt, rsmaior, rsmrt, rsneg} = flags;
		cur_name = name;
		check_en = 1'b1;
		n_driven++;
	endtask

	// ------------------------------------------------------------------
	// Checker, inputs captured at the edge, outputs read half a cycle on
	// ------------------------------------------------------------------
	initial
	begin : compare_proc
		logic [46:0] exp_v;
		logic [46:0] act_v;
		string nm;
		logic [5:0] op_s;
		logic [5:0] fn_s;
		forever
		begin
			@(posedge clk);
			if (check_en)
			begin
				exp_v = expected_out(opcode, funct, rt_code, equalrsrt, rsmaior, rsmrt, rsneg);
				nm = cur_name;
				op_s = opcode;
				fn_s = funct;
				@(negedge clk);
				act_v = {ctrol, outsaida, rt, slt_mux, zero_ext, jr_ctrl};
				n_checked++;
				assert (act_v === exp_v)
				else
				begin
					n_mismatch++;
					$display("mismatch %s (opcode %0d funct %0d): expected %h, actual %h",
						nm, op_s, fn_s, exp_v, act_v);
				end
			end
		end
	end

	// Watchdog sized from the vector counts
	initial
	begin
		#(TIMEOUT_NS);
		$display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("Test FAILED");
		$finish;
	end

	// ------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------
	initial
	begin : stim
		logic [31:0] r;
		logic [31:0] f;
		logic [4:0] rtc;
		logic [46:0] act_v;
		lfsr = 32'h2210;
		check_en = 1'b0;
		cur_name = "idle";
		n_driven = 0;
		n_checked = 0;
		n_mismatch = 0;
		n_other = 0;
		rst_n = 1'b0;
		opcode = '0;
		funct = '0;
		rt_code = '0;
		{equalrsrt, rsmaior, rsmrt, rsneg} = 4'b0;
		kept_ops = '{OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_ADDI,
			OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LW, OP_SW};
		kept_fns = '{6'd8, 6'd9, 6'd32, 6'd33, 6'd34, 6'd35, 6'd36, 6'd37, 6'd38, 6'd39,
			6'd42, 6'd43};
		shift_fns = '{6'd0, 6'd2, 6'd3, 6'd4, 6'd6, 6'd7};

		// Four reset edges, outputs checked before any instruction
		repeat (N_RESET) @(negedge clk);
		act_v = {ctrol, outsaida, rt, slt_mux, zero_ext, jr_ctrl};
		assert (act_v === 47'd0)
		else
		begin
			n_mismatch++;
			$display("mismatch reset: expected %h, actual %h", 47'd0, act_v);
		end
		rst_n = 1'b1;

		// Every kept opcode and funct, random flags and fields
		for (int k = 0; k < 4; k++)
		begin
			for (int i = 0; i < 16; i++)
			begin
				take_bits(4, f);
				take_bits(11, r);
				apply("kept opcode", kept_ops[i], r[5:0], r[10:6], f[3:0]);
			end
			for (int i = 0; i < 12; i++)
			begin
				take_bits(4, f);
				take_bits(5, r);
				apply("kept funct", OP_SPECIAL, kept_fns[i], r[4:0], f[3:0]);
			end
		end

		// BEQ, BNE, BLEZ, BGTZ over all flag combinations
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 16; j++)
			begin
				take_bits(11, r);
				apply("branch", kept_ops[3 + i], r[5:0], r[10:6], j[3:0]);
			end
		// REGIMM with rt 0 (BLTZ) and three non-zero rt values (BGEZ)
		for (int i = 0; i < 4; i++)
		begin
			take_bits(5, r);
			rtc = (i == 0) ? 5'd0 : ((r[4:0] == 5'd0) ? 5'd1 : r[4:0]);
			for (int j = 0; j < 16; j++)
			begin
				take_bits(6, r);
				apply("branch regimm", OP_REGIMM, r[5:0], rtc, j[3:0]);
			end
		end

		// SLTI, SLTIU, SLT, SLTU
		for (int i = 0; i < 4; i++)
			for (int j = 0; j < 16; j++)
			begin
				take_bits(11, r);
				if (i < 2)
					apply("set less than", (i == 0) ? OP_SLTI : OP_SLTIU, r[5:0], r[10:6],
						j[3:0]);
				else
					apply("set less than", OP_SPECIAL, (i == 2) ? 6'd42 : 6'd43, r[10:6],
						j[3:0]);
			end

		// Dropped shifts, LUI, then random encodings
		for (int i = 0; i < 6; i++)
		begin
			take_bits(9, r);
			apply("no-op shift", OP_SPECIAL, shift_fns[i], r[4:0], r[8:5]);
		end
		take_bits(15, r);
		apply("no-op lui", 6'd15, r[5:0], r[10:6], r[14:11]);
		for (int i = 0; i < 40; i++)
		begin
			take_bits(21, r);
			apply("random encoding", r[5:0], r[11:6], r[16:12], r[20:17]);
		end

		// Back-to-back mix of kept and random instructions
		for (int i = 0; i < N_B2B; i++)
		begin
			take_bits(1, r);
			take_bits(9, f);
			if (r[0])
			begin
				take_bits(5, r);
				if (r[4:0] % 28 < 16)
					apply("back-to-back", kept_ops[r[4:0] % 28], 6'd0, f[4:0], f[8:5]);
				else
					apply("back-to-back", OP_SPECIAL, kept_fns[r[4:0] % 28 - 16], f[4:0],
						f[8:5]);
			end
			else
			begin
				take_bits(12, r);
				apply("back-to-back", r[5:0], r[11:6], f[4:0], f[8:5]);
			end
		end

		@(negedge clk);
		check_en = 1'b0;
		@(negedge clk);

		// Every driven vector needs a compare
		assert (n_checked == n_driven)
		else
		begin
			n_other++;
			$display("checker compared %0d vectors but %0d were driven", n_checked, n_driven);
		end
		// Failures of the bound concurrent assertions
		assert (DUT.u_sva.n_fail == 0)
		else
		begin
			n_other++;
			$display("concurrent assertions failed %0d times", DUT.u_sva.n_fail);
		end
		$display("checks %0d, mismatches %0d, other errors %0d", n_checked, n_mismatch,
			n_other);
		if (n_mismatch == 0 && n_other == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
